// ==== verilog.f ====
+incdir+testbench
logic/ldpc_pkg.sv
logic/core_parity.sv
logic/check_row.sv
logic/codeword_packer.sv
logic/ldpc_encoder.sv
testbench/tb_ldpc_encoder.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary -j 0
TOP      = tb_ldpc_encoder
FILELIST = verilog.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

// ==== testbench/ldpc_model.svh ====
`ifndef LDPC_MODEL_SVH
`define LDPC_MODEL_SVH

// expected encoder output built from the base graph tables

// bit m of the result takes bit (m + s) mod ZC of the block
function automatic block_t rotate_block(input block_t b, input int s);
    block_t r;
    for (int m = 0; m < ZC; m++) begin
        r[m] = b[(m + s) % ZC];
    end
    return r;
endfunction

// pa0..pa3 from the four core rows with pa0 in the lsbs
function automatic core_t compute_core(input info_t d);
    info_shifts_t sh;
    block_t       lam [CORE_ROWS];
    block_t       p [CORE_ROWS];
    block_t       sum;
    sum = '0;
    for (int r = 0; r < CORE_ROWS; r++) begin
        lam[r] = '0;
        sh = a_row(r);
        for (int c = 0; c < KB; c++) begin
            if (int'(sh[c]) >= 0) begin   // negative entry means no edge
                lam[r] = lam[r] ^ rotate_block(d[c*ZC +: ZC], int'(sh[c]));
            end
        end
        sum = sum ^ lam[r];
    end
    for (int m = 0; m < ZC; m++) begin
        p[0][m] = sum[(m + ZC - 1) % ZC];   // bit m gets bit m-1
    end
    p[1] = p[0] ^ lam[0];
    p[2] = p[1] ^ lam[1];
    p[3] = p[0] ^ lam[3];
    return {p[3], p[2], p[1], p[0]};
endfunction

function automatic ext_t compute_ext(input info_t d, input core_t cp);
    bg_row_t row;
    block_t  blk;
    ext_t    e;
    for (int i = 0; i < EXT_ROWS; i++) begin
        row = ext_row(i);
        blk = '0;
        for (int c = 0; c < KB; c++) begin
            if (int'(row.info[c]) >= 0) begin
                blk = blk ^ rotate_block(d[c*ZC +: ZC], int'(row.info[c]));
            end
        end
        for (int p = 0; p < CORE_ROWS; p++) begin
            if (int'(row.core[p]) >= 0) begin
                blk = blk ^ rotate_block(cp[p*ZC +: ZC], int'(row.core[p]));
            end
        end
        e[i*ZC +: ZC] = blk;
    end
    return e;
endfunction

// zero padded word of systematic 2..9 then core then extension
function automatic out_t expected_codeword(input info_t d);
    out_t  w;
    core_t cp;
    ext_t  e;
    cp = compute_core(d);
    e  = compute_ext(d, cp);
    w  = '0;
    w[(KB-PUNCT_BLOCKS)*ZC-1:0] = d[KB*ZC-1:PUNCT_BLOCKS*ZC];
    w[(KB-PUNCT_BLOCKS)*ZC +: CORE_ROWS*ZC] = cp;
    w[(KB-PUNCT_BLOCKS+CORE_ROWS)*ZC +: EXT_ROWS*ZC] = e;
    return w;
endfunction

`endif

// ==== testbench/tb_ldpc_encoder.sv ====
`timescale 1ns/10ps

module tb_ldpc_encoder import ldpc_pkg::*; ();

    localparam int NUM_WORDS = 200;
    localparam int NUM_PAIRS = 8;
    localparam int LIMIT     = 200 + 4*NUM_WORDS;   // cycles
    localparam int SYS_W     = (KB-PUNCT_BLOCKS)*ZC;

    logic  CLK;
    logic  RST;
    logic  active;
    logic  enable;
    info_t data;
    out_t  data_out;
    logic  valid;

    integer seed;
    int     errors;
    int     checks;
    int     cycles;

    `include "ldpc_model.svh"

    ldpc_encoder dut (
        .CLK      (CLK),
        .RST      (RST),
        .data     (data),
        .active   (active),
        .enable   (enable),
        .data_out (data_out),
        .valid    (valid)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", LIMIT);
        $display("Done: errors found");
        $finish;
    end

    task automatic check(input out_t got, input out_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic out_t widen(input logic b);
        out_t w;
        w    = '0;
        w[0] = b;
        return w;
    endfunction

    function automatic info_t rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r[KB*ZC-1:0];
    endfunction

    // inputs change 2 ns after the edge
    task automatic step();
        @(posedge CLK);
        #2;
    endtask

    task automatic load_word(input info_t w);
        data   = w;
        active = 1'b1;
        step();
        active = 1'b0;
    endtask

    task automatic emit_and_check(input info_t w, input string what);
        enable = 1'b1;
        step();
        enable = 1'b0;
        check(widen(valid), widen(1'b1), {what, " valid"});
        check(data_out, expected_codeword(w), what);
    endtask

    task automatic finish_test(input string name, input int mark);
        $display("test %-10s errors: %0d", name, errors - mark);
    endtask

    initial begin
        info_t w;
        info_t a;
        info_t b;
        out_t  out_a;
        out_t  out_b;
        out_t  got_low;
        out_t  exp_low;
        int    mark;

        seed   = 32'hf5282de3;
        errors = 0;
        checks = 0;
        RST    = 1'b0;
        active = 1'b0;
        enable = 1'b0;
        data   = '0;
        repeat (10) @(posedge CLK);
        #2;
        RST = 1'b1;

        mark = errors;
        step();
        step();
        check(widen(valid), '0, "valid after reset");
        check(data_out, '0, "data_out after reset");
        // held registers come out of reset as the zero word
        emit_and_check('0, "held word after reset");
        finish_test("reset", mark);

        mark = errors;
        for (int i = 0; i < NUM_WORDS; i++) begin
            w = rand_word();
            load_word(w);
            emit_and_check(w, "random word");
            check(data_out >> $bits(codeword_t), '0, "upper pad bits");
            got_low = '0;
            got_low[SYS_W-1:0] = data_out[SYS_W-1:0];
            exp_low = '0;
            exp_low[SYS_W-1:0] = w[KB*ZC-1:PUNCT_BLOCKS*ZC];
            check(got_low, exp_low, "systematic bits");
        end
        finish_test("random", mark);

        mark = errors;
        w = rand_word();
        load_word(w);
        data   = ~w;    // not loaded, output must stay on w
        enable = 1'b1;
        step();
        repeat (4) begin
            check(widen(valid), widen(1'b1), "held enable valid");
            check(data_out, expected_codeword(w), "held enable codeword");
            step();
        end
        enable = 1'b0;
        step();
        check(widen(valid), '0, "valid after enable low");
        check(data_out, '0, "data_out after enable low");
        finish_test("hold", mark);

        // output still from the old word when load and emit share a cycle
        mark = errors;
        a = rand_word();
        b = rand_word();
        load_word(a);
        data   = b;
        active = 1'b1;
        enable = 1'b1;
        step();
        active = 1'b0;
        enable = 1'b0;
        check(widen(valid), widen(1'b1), "overlap valid");
        check(data_out, expected_codeword(a), "overlap codeword");
        emit_and_check(b, "word after overlap");
        finish_test("overlap", mark);

        mark = errors;
        load_word('0);
        emit_and_check('0, "zero word");
        check(data_out, '0, "zero codeword");
        for (int i = 0; i < NUM_PAIRS; i++) begin
            a = rand_word();
            b = rand_word();
            load_word(a);
            emit_and_check(a, "word a");
            out_a = data_out;
            load_word(b);
            emit_and_check(b, "word b");
            out_b = data_out;
            load_word(a ^ b);
            emit_and_check(a ^ b, "word a^b");
            check(data_out, out_a ^ out_b, "linearity");
        end
        finish_test("linear", mark);

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== logic/ldpc_encoder.sv ====
`timescale 1ns/10ps

module ldpc_encoder import ldpc_pkg::*; (
    input  logic  CLK,
    input  logic  RST,
    input  info_t data,
    input  logic  active,
    input  logic  enable,
    output out_t  data_out,
    output logic  valid
);

    info_t info_q;   // held information word
    core_t core_q;   // held core parity
    ext_t  ext_par;

    core_parity u_core (
        .CLK    (CLK),
        .RST    (RST),
        .active (active),
        .data   (data),
        .info   (info_q),
        .core   (core_q)
    );

    // one combinational check per extension row
    for (genvar r = 0; r < EXT_ROWS; r++) begin : g_row
        check_row #(
            .ROW (r)
        ) u_row (
            .info   (info_q),
            .core   (core_q),
            .parity (ext_par[r*ZC +: ZC])
        );
    end

    codeword_packer u_pack (
        .CLK      (CLK),
        .RST      (RST),
        .enable   (enable),
        .info     (info_q),
        .core     (core_q),
        .ext      (ext_par),
        .data_out (data_out),
        .valid    (valid)
    );

endmodule

// ==== logic/codeword_packer.sv ====
`timescale 1ns/10ps

module codeword_packer import ldpc_pkg::*; (
    input  logic  CLK,
    input  logic  RST,
    input  logic  enable,
    input  info_t info,
    input  core_t core,
    input  ext_t  ext,
    output out_t  data_out,
    output logic  valid
);

    localparam int PAD_W = OUT_W - $bits(codeword_t);   // unused msbs

    codeword_t cw;

    always_comb begin
        cw.ext  = ext;
        cw.core = core;
        cw.sys  = info[KB*ZC-1:PUNCT_BLOCKS*ZC];   // first two blocks punctured
    end

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            data_out <= '0;
            valid    <= 1'b0;
        end else if (enable) begin
            data_out <= {{PAD_W{1'b0}}, cw};
            valid    <= 1'b1;
        end else begin
            // idle output is all zero
            data_out <= '0;
            valid    <= 1'b0;
        end
    end

endmodule

// ==== logic/check_row.sv ====
`timescale 1ns/10ps

module check_row import ldpc_pkg::*; #(
    parameter int ROW = 0
) (
    input  info_t  info,
    input  core_t  core,
    output block_t parity
);

    localparam bg_row_t SH = ext_row(ROW);

    // circulant rotation by s
    function automatic block_t rot(input block_t b, input shift_t s);
        block_t r;
        for (int m = 0; m < ZC; m++) begin
            r[m] = b[(m + int'(s)) % ZC];
        end
        return r;
    endfunction

    always_comb begin
        parity = '0;
        for (int c = 0; c < KB; c++) begin
            if (SH.info[c] != NO_EDGE) begin
                parity = parity ^ rot(info[c*ZC +: ZC], SH.info[c]);
            end
        end
        // contribution of core parity blocks
        for (int p = 0; p < CORE_ROWS; p++) begin
            if (SH.core[p] != NO_EDGE) begin
                parity = parity ^ rot(core[p*ZC +: ZC], SH.core[p]);
            end
        end
    end

endmodule

// ==== logic/core_parity.sv ====
`timescale 1ns/10ps

module core_parity import ldpc_pkg::*; (
    input  logic  CLK,
    input  logic  RST,
    input  logic  active,
    input  info_t data,
    output info_t info,
    output core_t core
);

    block_t [CORE_ROWS-1:0] lambda;
    block_t lam_sum;
    block_t pa0;
    block_t pa1;
    block_t pa2;
    block_t pa3;

    // lambda of each core row is a sum of rotated info blocks
    always_comb begin
        info_shifts_t sh;
        block_t       blk;
        lambda = '0;
        for (int r = 0; r < CORE_ROWS; r++) begin
            sh = a_row(r);
            for (int c = 0; c < KB; c++) begin
                blk = data[c*ZC +: ZC];
                if (sh[c] != NO_EDGE) begin
                    for (int m = 0; m < ZC; m++) begin
                        // out bit m takes in bit (m + shift) mod ZC
                        lambda[r][m] = lambda[r][m] ^ blk[(m + int'(sh[c])) % ZC];
                    end
                end
            end
        end
    end

    assign lam_sum = lambda[0] ^ lambda[1] ^ lambda[2] ^ lambda[3];

    // double diagonal solve
    assign pa0 = {lam_sum[ZC-2:0], lam_sum[ZC-1]};  // rotate up by one
    assign pa1 = pa0 ^ lambda[0];
    assign pa2 = pa1 ^ lambda[1];
    assign pa3 = pa0 ^ lambda[3];

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            info <= '0;
            core <= '0;
        end else if (active) begin
            info <= data;
            core <= {pa3, pa2, pa1, pa0};   // pa0 in the lsbs
        end
    end

endmodule

// ==== logic/ldpc_pkg.sv ====
package ldpc_pkg;

    localparam int ZC           = 2;    // lifting size
    localparam int KB           = 10;   // information columns
    localparam int CORE_ROWS    = 4;
    localparam int EXT_ROWS     = 38;
    localparam int PUNCT_BLOCKS = 2;    // leading systematic blocks not sent
    localparam int OUT_W        = 127;

    typedef logic signed [3:0] shift_t;
    localparam shift_t NO_EDGE = -4'sd1;    // empty circulant

    typedef logic [ZC-1:0]                  block_t;
    typedef logic [KB*ZC-1:0]               info_t;
    typedef logic [CORE_ROWS*ZC-1:0]        core_t;
    typedef logic [EXT_ROWS*ZC-1:0]         ext_t;
    typedef logic [(KB-PUNCT_BLOCKS)*ZC-1:0] sys_t;
    typedef logic [OUT_W-1:0]               out_t;

    // ascending ranges so table literals read column 0 first
    typedef shift_t [0:KB-1]        info_shifts_t;
    typedef shift_t [0:CORE_ROWS-1] core_shifts_t;

    typedef struct packed {
        ext_t  ext;     // extension parity in the msbs
        core_t core;    // pa3..pa0
        sys_t  sys;     // systematic blocks 2..9 in the lsbs
    } codeword_t;

    typedef struct packed {
        info_shifts_t info;
        core_shifts_t core;
    } bg_row_t;

    // core rows where F marks no connection
    function automatic info_shifts_t a_row(input int i);
        case (i)
            0:       return 40'h1100FF1FF1;
            1:       return 40'h1FF0110000;
            2:       return 40'h10F00FFF0F;
            default: return 40'hF00F001000;
        endcase
    endfunction

    // extension rows with info columns ahead of core columns
    function automatic bg_row_t ext_row(input int i);
        case (i)
            0:       return 56'h10FFFFFFFF_F1FF;
            1:       return 56'h11FFF0F1FF_F1FF;
            2:       return 56'h1FFFF0F1F0_F0FF;
            3:       return 56'hF1FFF1F0FF_F1F0;
            4:       return 56'h00FFFFFFFF_FF0F;
            5:       return 56'hF1FFFFFF1F_11FF;
            6:       return 56'h11FFFF01FF_FFFF;
            7:       return 56'h1FFFFFF0F0_FFF0;
            8:       return 56'hF1F1FFFFFF_F0FF;
            9:       return 56'h10FFFFFF0F_FFF0;
            10:      return 56'hF1FFFF1FFF_F1F0;
            11:      return 56'h1FFFFFFFFF_11FF;
            12:      return 56'hF1FFFFFFF0_F00F;
            13:      return 56'hF0FFF0FFFF_F00F;
            14:      return 56'h0FFFFF00FF_FFFF;
            15:      return 56'h10FFFFFFFF_1FFF;
            16:      return 56'hF0FF1FFFFF_F1FF;
            17:      return 56'h0FFFFFFF0F_FFF0;
            18:      return 56'hF01FFFFFFF_FFFF;
            19:      return 56'h1FF1F0FFFF_FFFF;
            20:      return 56'hF01FFFFFF0_FFFF;
            21:      return 56'h0FFFF0FFFF_FFFF;
            22:      return 56'hFF1FFFF1FF_FF00;
            23:      return 56'h0FFFFF1FFF_FFFF;
            24:      return 56'hF01FF1FFFF_FFFF;
            25:      return 56'h0FFF0FFFFF_FFFF;
            26:      return 56'hFF1FF0F1F0_FFFF;
            27:      return 56'hF0FFFFFFFF_FFF1;
            28:      return 56'h0FFFF0FFFF_FF0F;
            29:      return 56'hFF0FFFF0FF_1FFF;
            30:      return 56'h1FFFFFFFFF_FF10;
            31:      return 56'hF1FFF0FFFF_F1FF;
            32:      return 56'h0F0FFFF0FF_FFFF;
            33:      return 56'hFFFFFFFFFF_1FF1;
            34:      return 56'hF1FFF0FFFF_F0FF;
            35:      return 56'h1FFFFFF0FF_FF0F;
            36:      return 56'hFF0FFFFFFF_1FF0;
            default: return 56'hF1FFF1FFFF_F0FF;
        endcase
    endfunction

endpackage
